//--- hw/dac_interp_pkg.sv
package dac_interp_pkg;

  // One DAC sample, two's complement
  typedef logic signed [15:0] sample_t;

  // A stream word is either moved as a whole or split into its two channels
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      sample_t ch1;
      sample_t ch0;
    } ch;
  } dac_word_u;

  // ********************************************************************
  // Register map (byte offsets)
  // ********************************************************************
  localparam logic [31:0] REG_CTRL   = 32'h0;
  localparam logic [31:0] REG_STATUS = 32'h4;
  localparam logic [31:0] REG_COUNT  = 32'h8;

  localparam int CTRL_INTERP_BIT = 0;
  localparam int STATUS_SAT_BIT  = 0;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  // Half-band branch taps, the sum of all four is 16
  localparam int COEF_OUTER = -1;
  localparam int COEF_INNER = 9;
  localparam int COEF_SHIFT = 4;

endpackage

//--- hw/dac_interp_top.sv
`timescale 1ns/1ps

module dac_interp_top
  import dac_interp_pkg::*;
#(
  parameter int ADDR_W = 4
) (
  input  logic              aclk,
  input  logic              rst_n,
  input  logic              s_axis_data_tvalid,
  output logic              s_axis_data_tready,
  input  logic [31:0]       s_axis_data_tdata,
  output sample_t           channel_0,
  output sample_t           channel_1,
  output logic              m_axis_data_tvalid,
  input  logic              dac_read,
  input  logic [ADDR_W-1:0] s_axi_awaddr,
  input  logic              s_axi_awvalid,
  output logic              s_axi_awready,
  input  logic [31:0]       s_axi_wdata,
  input  logic              s_axi_wvalid,
  output logic              s_axi_wready,
  output axi_resp_t         s_axi_bresp,
  output logic              s_axi_bvalid,
  input  logic              s_axi_bready,
  input  logic [ADDR_W-1:0] s_axi_araddr,
  input  logic              s_axi_arvalid,
  output logic              s_axi_arready,
  output logic [31:0]       s_axi_rdata,
  output axi_resp_t         s_axi_rresp,
  output logic              s_axi_rvalid,
  input  logic              s_axi_rready
);

  // Mode and status between the register block and the sample path
  logic      interpolate;
  logic      sat_pulse;
  logic      sample_taken;
  // Stream between the output stage and the interpolator
  logic      fir_in_valid;
  logic      fir_in_ready;
  dac_word_u fir_in_word;
  logic      fir_out_valid;
  dac_word_u fir_out_word;

  interp_regs #(
    .ADDR_W(ADDR_W)
  ) regs_i (
    .aclk(aclk),
    .rst_n(rst_n),
    .s_axi_awaddr(s_axi_awaddr),
    .s_axi_awvalid(s_axi_awvalid),
    .s_axi_awready(s_axi_awready),
    .s_axi_wdata(s_axi_wdata),
    .s_axi_wvalid(s_axi_wvalid),
    .s_axi_wready(s_axi_wready),
    .s_axi_bresp(s_axi_bresp),
    .s_axi_bvalid(s_axi_bvalid),
    .s_axi_bready(s_axi_bready),
    .s_axi_araddr(s_axi_araddr),
    .s_axi_arvalid(s_axi_arvalid),
    .s_axi_arready(s_axi_arready),
    .s_axi_rdata(s_axi_rdata),
    .s_axi_rresp(s_axi_rresp),
    .s_axi_rvalid(s_axi_rvalid),
    .s_axi_rready(s_axi_rready),
    .interpolate(interpolate),
    .sat_pulse(sat_pulse),
    .sample_taken(sample_taken)
  );

  // The DAC strobe is the interpolator's output ready
  fir_interp fir_i (
    .aclk(aclk),
    .rst_n(rst_n),
    .interpolate(interpolate),
    .fir_in_valid(fir_in_valid),
    .fir_in_ready(fir_in_ready),
    .fir_in_word(fir_in_word),
    .fir_out_valid(fir_out_valid),
    .fir_out_ready(dac_read),
    .fir_out_word(fir_out_word),
    .sat_pulse(sat_pulse)
  );

  util_fir_int out_i (
    .aclk(aclk),
    .interpolate(interpolate),
    .s_axis_data_tvalid(s_axis_data_tvalid),
    .s_axis_data_tready(s_axis_data_tready),
    .s_axis_data_tdata(s_axis_data_tdata),
    .dac_read(dac_read),
    .fir_in_valid(fir_in_valid),
    .fir_in_ready(fir_in_ready),
    .fir_in_word(fir_in_word),
    .fir_out_valid(fir_out_valid),
    .fir_out_word(fir_out_word),
    .channel_0(channel_0),
    .channel_1(channel_1),
    .m_axis_data_tvalid(m_axis_data_tvalid),
    .sample_taken(sample_taken)
  );

endmodule

//--- hw/fir_interp.sv
`timescale 1ns/1ps

module fir_interp
  import dac_interp_pkg::*;
(
  input  logic      aclk,
  input  logic      rst_n,
  input  logic      interpolate,
  input  logic      fir_in_valid,
  output logic      fir_in_ready,
  input  dac_word_u fir_in_word,
  output logic      fir_out_valid,
  input  logic      fir_out_ready,
  output dac_word_u fir_out_word,
  output logic      sat_pulse
);

  // Limits of the 16-bit output range, held at the accumulator width
  localparam logic signed [31:0] SAT_MAX = 32'sd32767;
  localparam logic signed [31:0] SAT_MIN = -32'sd32768;

  // ********************************************************************
  // Sample history and branch arithmetic
  // ********************************************************************

  // Index 0 is channel 0, index 1 is channel 1
  sample_t            in_s [2];
  // Previous three accepted samples, together with the new one a four-tap window
  sample_t            hist [2][1:3];
  logic signed [31:0] acc [2];
  logic signed [31:0] acc_sh [2];
  sample_t            branch_s [2];
  logic [1:0]         sat_s;

  // Output sequencing
  logic      out_valid;
  logic      phase;
  logic      in_fire;
  dac_word_u out_word0;
  dac_word_u out_word1;

  always_comb begin
    in_s[0] = fir_in_word.ch.ch0;
    in_s[1] = fir_in_word.ch.ch1;
    for (int c = 0; c < 2; c++) begin
      // Centre branch, symmetric around the midpoint between x[k-2] and x[k-1]
      acc[c] = COEF_OUTER * hist[c][3] + COEF_INNER * hist[c][2] +
               COEF_INNER * hist[c][1] + COEF_OUTER * in_s[c];
      // Arithmetic shift, so negative sums round toward minus infinity
      acc_sh[c] = acc[c] >>> COEF_SHIFT;
      if (acc_sh[c] > SAT_MAX) begin
        branch_s[c] = sample_t'(SAT_MAX);
        sat_s[c]    = 1'b1;
      end else if (acc_sh[c] < SAT_MIN) begin
        branch_s[c] = sample_t'(SAT_MIN);
        sat_s[c]    = 1'b1;
      end else begin
        branch_s[c] = acc_sh[c][15:0];
        sat_s[c]    = 1'b0;
      end
    end
  end

  // ********************************************************************
  // Phase control
  // ********************************************************************

  // A new word is only taken once both outputs of the last one are gone
  assign fir_in_ready = ~out_valid;
  assign in_fire      = fir_in_valid & fir_in_ready & interpolate;

  always_ff @(posedge aclk) begin
    // Leaving interpolate mode drops the history and any pair in flight
    if (!rst_n || !interpolate) begin
      out_valid <= 1'b0;
      phase     <= 1'b0;
      sat_pulse <= 1'b0;
      hist      <= '{default: '0};
    end else begin
      sat_pulse <= 1'b0;
      if (in_fire) begin
        out_valid <= 1'b1;
        phase     <= 1'b0;
        sat_pulse <= |sat_s;
        for (int c = 0; c < 2; c++) begin
          hist[c][3] <= hist[c][2];
          hist[c][2] <= hist[c][1];
          hist[c][1] <= in_s[c];
        end
      end else if (out_valid && fir_out_ready) begin
        // First phase consumed, present the second one next cycle
        if (!phase) begin
          phase <= 1'b1;
        end else begin
          out_valid <= 1'b0;
          phase     <= 1'b0;
        end
      end
    end
  end

  // Both output words are captured together when the input is accepted
  always_ff @(posedge aclk) begin
    if (in_fire) begin
      // Zero-phase branch is the delayed sample itself
      out_word0.ch.ch0 <= hist[0][2];
      out_word0.ch.ch1 <= hist[1][2];
      out_word1.ch.ch0 <= branch_s[0];
      out_word1.ch.ch1 <= branch_s[1];
    end
  end

  assign fir_out_valid = out_valid;
  assign fir_out_word  = phase ? out_word1 : out_word0;

endmodule

//--- hw/interp_regs.sv
`timescale 1ns/1ps

module interp_regs
  import dac_interp_pkg::*;
#(
  parameter int ADDR_W = 4
) (
  input  logic              aclk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] s_axi_awaddr,
  input  logic              s_axi_awvalid,
  output logic              s_axi_awready,
  input  logic [31:0]       s_axi_wdata,
  input  logic              s_axi_wvalid,
  output logic              s_axi_wready,
  output axi_resp_t         s_axi_bresp,
  output logic              s_axi_bvalid,
  input  logic              s_axi_bready,
  input  logic [ADDR_W-1:0] s_axi_araddr,
  input  logic              s_axi_arvalid,
  output logic              s_axi_arready,
  output logic [31:0]       s_axi_rdata,
  output axi_resp_t         s_axi_rresp,
  output logic              s_axi_rvalid,
  input  logic              s_axi_rready,
  output logic              interpolate,
  input  logic              sat_pulse,
  input  logic              sample_taken
);

  // Addresses widened so that the map compares at a fixed width
  logic [31:0] wr_addr;
  logic [31:0] rd_addr;
  logic        wr_en;
  logic        wr_hit;
  logic        rd_hit;
  logic [31:0] rd_value;

  // Register state
  logic        ctrl_interp;
  logic        sat_flag;
  logic [31:0] count;

  // ********************************************************************
  // Address decode
  // ********************************************************************
  assign wr_addr = 32'(s_axi_awaddr);
  assign rd_addr = 32'(s_axi_araddr);

  // Write strobe is the handshake cycle itself
  assign wr_en  = s_axi_awready & s_axi_wready;
  assign wr_hit = (wr_addr == REG_CTRL) || (wr_addr == REG_STATUS) || (wr_addr == REG_COUNT);
  assign rd_hit = (rd_addr == REG_CTRL) || (rd_addr == REG_STATUS) || (rd_addr == REG_COUNT);

  always_comb begin
    rd_value = 32'h0;
    if (rd_addr == REG_CTRL) begin
      rd_value[CTRL_INTERP_BIT] = ctrl_interp;
    end else if (rd_addr == REG_STATUS) begin
      rd_value[STATUS_SAT_BIT] = sat_flag;
    end else if (rd_addr == REG_COUNT) begin
      rd_value = count;
    end
  end

  // ********************************************************************
  // Write channel
  // ********************************************************************
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      s_axi_bresp   <= RESP_OKAY;
    end else begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      // Address and data are taken together, one write outstanding at a time
      if (!s_axi_awready && !s_axi_bvalid && s_axi_awvalid && s_axi_wvalid) begin
        s_axi_awready <= 1'b1;
        s_axi_wready  <= 1'b1;
      end
      if (wr_en) begin
        s_axi_bvalid <= 1'b1;
        s_axi_bresp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      end else if (s_axi_bvalid && s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  // ********************************************************************
  // Read channel
  // ********************************************************************
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
      s_axi_rresp   <= RESP_OKAY;
    end else begin
      s_axi_arready <= s_axi_arvalid & ~s_axi_arready & ~s_axi_rvalid;
      if (s_axi_arready) begin
        s_axi_rvalid <= 1'b1;
        s_axi_rresp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
      end else if (s_axi_rvalid && s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  // Unmapped offsets decode to zero in rd_value
  always_ff @(posedge aclk) begin
    if (s_axi_arready) begin
      s_axi_rdata <= rd_value;
    end
  end

  // ********************************************************************
  // Registers
  // ********************************************************************
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      ctrl_interp <= 1'b0;
      sat_flag    <= 1'b0;
      count       <= 32'h0;
    end else begin
      if (wr_en && wr_addr == REG_CTRL) begin
        ctrl_interp <= s_axi_wdata[CTRL_INTERP_BIT];
      end
      if (wr_en && wr_addr == REG_STATUS && s_axi_wdata[STATUS_SAT_BIT]) begin
        sat_flag <= 1'b0;
      end
      // A new saturation wins over a clear in the same cycle
      if (sat_pulse) begin
        sat_flag <= 1'b1;
      end
      if (sample_taken) begin
        count <= count + 32'd1;
      end
    end
  end

  assign interpolate = ctrl_interp;

endmodule

//--- hw/util_fir_int.sv
`timescale 1ns/1ps

module util_fir_int
  import dac_interp_pkg::*;
(
  input  logic      aclk,
  input  logic      interpolate,
  input  logic      s_axis_data_tvalid,
  output logic      s_axis_data_tready,
  input  dac_word_u s_axis_data_tdata,
  input  logic      dac_read,
  output logic      fir_in_valid,
  input  logic      fir_in_ready,
  output dac_word_u fir_in_word,
  input  logic      fir_out_valid,
  input  dac_word_u fir_out_word,
  output sample_t   channel_0,
  output sample_t   channel_1,
  output logic      m_axis_data_tvalid,
  output logic      sample_taken
);

  // Word chosen for the DAC in the current mode
  dac_word_u out_word;

  // ********************************************************************
  // Mode-dependent flow control
  // ********************************************************************

  // The interpolator sees traffic only in interpolate mode
  assign fir_in_valid = s_axis_data_tvalid & interpolate;
  assign fir_in_word  = s_axis_data_tdata;

  always_comb begin
    if (interpolate) begin
      // Source is paced by the FIR, the DAC by the FIR output
      s_axis_data_tready = fir_in_ready;
      m_axis_data_tvalid = fir_out_valid;
      out_word           = fir_out_word;
    end else begin
      // Bypass is a pure combinational path, the DAC paces the source directly
      s_axis_data_tready = dac_read;
      m_axis_data_tvalid = s_axis_data_tvalid;
      out_word           = s_axis_data_tdata;
    end
  end

  // Upper half is channel 1, lower half channel 0
  assign channel_0 = out_word.ch.ch0;
  assign channel_1 = out_word.ch.ch1;

  // One pulse per sample the DAC actually took, for the delivered count
  always_ff @(posedge aclk) begin
    sample_taken <= m_axis_data_tvalid & dac_read;
  end

endmodule

//--- tb.f
hw/dac_interp_pkg.sv
hw/interp_regs.sv
hw/fir_interp.sv
hw/util_fir_int.sv
hw/dac_interp_top.sv
verification/tb_clk_gen.sv
verification/dac_interp_asserts.sv
verification/tb_dac_interp.sv

//--- verification/dac_interp_asserts.sv
`timescale 1ns/1ps

module dac_interp_asserts
  import dac_interp_pkg::*;
(
  input logic    aclk,
  input logic    rst_n,
  input logic    s_axi_awready,
  input logic    s_axi_arready,
  input logic    s_axi_bvalid,
  input logic    s_axi_bready,
  input logic    s_axi_rvalid,
  input logic    s_axi_rready,
  input logic    m_axis_data_tvalid,
  input logic    dac_read,
  input sample_t channel_0,
  input sample_t channel_1
);

  // One flag per property, so each one has a single writer
  bit   bvalid_bad;
  bit   rvalid_bad;
  bit   out_bad;
  bit   reset_bad;
  logic failed;

  assign failed = bvalid_bad | rvalid_bad | out_bad | reset_bad;

  // A write response stays up until the master takes it
  bvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else begin
      $error("bvalid dropped before bready");
      bvalid_bad = 1'b1;
    end

  // Same rule for read data
  rvalid_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
    else begin
      $error("rvalid dropped before rready");
      rvalid_bad = 1'b1;
    end

  // A sample offered to the DAC does not move until dac_read takes it
  out_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      m_axis_data_tvalid && !dac_read |=>
      m_axis_data_tvalid && $stable(channel_0) && $stable(channel_1))
    else begin
      $error("DAC sample changed or vanished while stalled");
      out_bad = 1'b1;
    end

  // Every handshake output is quiet one cycle into reset
  reset_quiet: assert property (@(posedge aclk)
      !rst_n |=> !s_axi_awready && !s_axi_arready && !s_axi_bvalid &&
      !s_axi_rvalid && !m_axis_data_tvalid)
    else begin
      $error("valid or ready high after reset");
      reset_bad = 1'b1;
    end

endmodule

bind dac_interp_top dac_interp_asserts asserts_i (
  .aclk(aclk),
  .rst_n(rst_n),
  .s_axi_awready(s_axi_awready),
  .s_axi_arready(s_axi_arready),
  .s_axi_bvalid(s_axi_bvalid),
  .s_axi_bready(s_axi_bready),
  .s_axi_rvalid(s_axi_rvalid),
  .s_axi_rready(s_axi_rready),
  .m_axis_data_tvalid(m_axis_data_tvalid),
  .dac_read(dac_read),
  .channel_0(channel_0),
  .channel_1(channel_1)
);

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic aclk
);

  // Free-running clock, low for the first half period
  initial begin
    aclk = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2);
    aclk = ~aclk;
  end

endmodule

//--- verification/tb_dac_interp.sv
`timescale 1ns/1ps

module tb_dac_interp
  import dac_interp_pkg::*;
();

  localparam int ADDR_W    = 4;
  localparam int DRIVE_DLY = 10;
  localparam int TIMEOUT   = 64;

  logic              aclk;
  logic              rst_n;
  logic              s_axis_data_tvalid;
  logic              s_axis_data_tready;
  logic [31:0]       s_axis_data_tdata;
  sample_t           channel_0;
  sample_t           channel_1;
  logic              m_axis_data_tvalid;
  logic              dac_read;
  logic [ADDR_W-1:0] s_axi_awaddr;
  logic              s_axi_awvalid;
  logic              s_axi_awready;
  logic [31:0]       s_axi_wdata;
  logic              s_axi_wvalid;
  logic              s_axi_wready;
  axi_resp_t         s_axi_bresp;
  logic              s_axi_bvalid;
  logic              s_axi_bready;
  logic [ADDR_W-1:0] s_axi_araddr;
  logic              s_axi_arvalid;
  logic              s_axi_arready;
  logic [31:0]       s_axi_rdata;
  axi_resp_t         s_axi_rresp;
  logic              s_axi_rvalid;
  logic              s_axi_rready;

  // Model state holds x[k-1], x[k-2], x[k-3] per channel and the expected sticky flag
  integer seed;
  int     model_hist [2][3];
  logic   model_sat;
  int     taken;

  tb_clk_gen #(.PERIOD_NS(100)) clk_i (.aclk(aclk));

  dac_interp_top #(.ADDR_W(ADDR_W)) dut_i (.*);

  // **********************************************************************
  // Failure reporting and compare tasks
  // **********************************************************************
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input dac_word_u exp, input dac_word_u act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp.raw, act.raw);
      $display("test failed");
      $fatal(1, "sample mismatch");
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      $display("test failed");
      $fatal(1, "response mismatch");
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("test failed");
      $fatal(1, "register mismatch");
    end
  endtask

  // One more cycle of waiting, counted against the timeout
  task automatic step_wait(inout int n, input string what);
    n++;
    if (n > TIMEOUT) begin
      fail_now({"timed out waiting for ", what});
    end
    @(negedge aclk);
  endtask

  // **********************************************************************
  // Bus and stream drivers
  // **********************************************************************
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           output axi_resp_t resp);
    int n;
    s_axi_awaddr  = addr[ADDR_W-1:0];
    s_axi_wdata   = data;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    n = 0;
    @(negedge aclk);
    while (!(s_axi_awready && s_axi_wready)) step_wait(n, "awready and wready");
    @(posedge aclk);
    #DRIVE_DLY;
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    n = 0;
    @(negedge aclk);
    while (!s_axi_bvalid) step_wait(n, "bvalid");
    // The master takes the response one cycle late, so bvalid must hold
    @(posedge aclk);
    #DRIVE_DLY;
    s_axi_bready = 1'b1;
    @(negedge aclk);
    resp = s_axi_bresp;
    @(posedge aclk);
    #DRIVE_DLY;
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                          output axi_resp_t resp);
    int n;
    s_axi_araddr  = addr[ADDR_W-1:0];
    s_axi_arvalid = 1'b1;
    n = 0;
    @(negedge aclk);
    while (!s_axi_arready) step_wait(n, "arready");
    @(posedge aclk);
    #DRIVE_DLY;
    s_axi_arvalid = 1'b0;
    n = 0;
    @(negedge aclk);
    while (!s_axi_rvalid) step_wait(n, "rvalid");
    @(posedge aclk);
    #DRIVE_DLY;
    s_axi_rready = 1'b1;
    @(negedge aclk);
    data = s_axi_rdata;
    resp = s_axi_rresp;
    @(posedge aclk);
    #DRIVE_DLY;
    s_axi_rready = 1'b0;
  endtask

  task automatic write_ok(input string name, input logic [31:0] addr, input logic [31:0] data);
    axi_resp_t resp;
    axi_write(addr, data, resp);
    check_resp(name, RESP_OKAY, resp);
  endtask

  task automatic read_expect(input string name, input logic [31:0] addr,
                             input logic [31:0] exp);
    logic [31:0] data;
    axi_resp_t   resp;
    axi_read(addr, data, resp);
    check_resp(name, RESP_OKAY, resp);
    check_reg(name, exp, data);
  endtask

  task automatic send_word(input dac_word_u w);
    int n;
    s_axis_data_tdata  = w.raw;
    s_axis_data_tvalid = 1'b1;
    n = 0;
    @(negedge aclk);
    while (!s_axis_data_tready) step_wait(n, "s_axis_data_tready");
    @(posedge aclk);
    #DRIVE_DLY;
    s_axis_data_tvalid = 1'b0;
  endtask

  task automatic take_sample(input string name, input dac_word_u exp);
    int        n;
    dac_word_u act;
    dac_read = 1'b1;
    n = 0;
    @(negedge aclk);
    while (!m_axis_data_tvalid) step_wait(n, "m_axis_data_tvalid");
    act.ch.ch0 = channel_0;
    act.ch.ch1 = channel_1;
    check_word(name, exp, act);
    @(posedge aclk);
    #DRIVE_DLY;
    dac_read = 1'b0;
    taken++;
  endtask

  // With the DAC stalled the offered sample stays valid and the source is refused
  task automatic hold_off(input int cycles, input string name);
    dac_read = 1'b0;
    repeat (cycles) begin
      @(negedge aclk);
      if (!m_axis_data_tvalid) begin
        fail_now({name, ": output valid dropped while the DAC was stalled"});
      end
      if (s_axis_data_tready) begin
        fail_now({name, ": source was ready while the DAC was stalled"});
      end
    end
    @(posedge aclk);
    #DRIVE_DLY;
  endtask

  task automatic expect_idle(input string name);
    @(negedge aclk);
    if (m_axis_data_tvalid) begin
      fail_now({name, ": an extra output sample appeared"});
    end
    @(posedge aclk);
    #DRIVE_DLY;
  endtask

  // **********************************************************************
  // Reference model of the 2x interpolator
  // **********************************************************************
  task automatic model_clear();
    model_hist = '{default: 0};
  endtask

  task automatic model_push(input dac_word_u w, output dac_word_u first,
                            output dac_word_u second);
    int      x [2];
    int      acc;
    sample_t f [2];
    sample_t s [2];
    x[0] = w.ch.ch0;
    x[1] = w.ch.ch1;
    for (int c = 0; c < 2; c++) begin
      // Even phase is x[k-2] itself
      f[c] = sample_t'(model_hist[c][1]);
      // Odd phase taps -1, 9, 9, -1 over x[k-3] .. x[k], floor division by 16
      acc = (9 * model_hist[c][1] + 9 * model_hist[c][0] - model_hist[c][2] - x[c]) >>> 4;
      if (acc > 32767) begin
        acc = 32767;
        model_sat = 1'b1;
      end else if (acc < -32768) begin
        acc = -32768;
        model_sat = 1'b1;
      end
      s[c] = sample_t'(acc);
      model_hist[c][2] = model_hist[c][1];
      model_hist[c][1] = model_hist[c][0];
      model_hist[c][0] = x[c];
    end
    first.ch.ch0  = f[0];
    first.ch.ch1  = f[1];
    second.ch.ch0 = s[0];
    second.ch.ch1 = s[1];
  endtask

  // The DUT drops its history whenever interpolation is off
  task automatic set_mode(input logic interp);
    write_ok("set_mode", REG_CTRL, {31'b0, interp});
    model_clear();
  endtask

  // **********************************************************************
  // Directed tests
  // **********************************************************************
  task automatic test_reset_regs();
    read_expect("reset_ctrl", REG_CTRL, 32'h0);
    read_expect("reset_status", REG_STATUS, 32'h0);
    read_expect("reset_count", REG_COUNT, 32'h0);
    write_ok("ctrl_write", REG_CTRL, 32'h1);
    read_expect("ctrl_readback", REG_CTRL, 32'h1);
    set_mode(1'b0);
    read_expect("ctrl_cleared", REG_CTRL, 32'h0);
  endtask

  task automatic test_bypass();
    dac_word_u w;
    for (int i = 0; i < 8; i++) begin
      w.raw = $random(seed);
      fork
        send_word(w);
        take_sample("bypass", w);
      join
    end
    // Source waits on a stalled DAC
    w.raw = $random(seed);
    s_axis_data_tdata  = w.raw;
    s_axis_data_tvalid = 1'b1;
    hold_off(4, "bypass_stall");
    fork
      send_word(w);
      take_sample("bypass_after_stall", w);
    join
    read_expect("bypass_count", REG_COUNT, taken);
  endtask

  task automatic test_interp();
    dac_word_u w;
    dac_word_u e0;
    dac_word_u e1;
    set_mode(1'b1);
    for (int i = 0; i < 12; i++) begin
      w.raw = $random(seed);
      if (i == 2) begin
        w.ch.ch0 = -16'sd1200;
      end
      if (i == 3) begin
        w.ch.ch1 = -16'sd20000;
      end
      model_push(w, e0, e1);
      send_word(w);
      take_sample("interp_phase0", e0);
      take_sample("interp_phase1", e1);
    end
    expect_idle("interp");
    read_expect("interp_count", REG_COUNT, taken);
    read_expect("interp_status", REG_STATUS, {31'b0, model_sat});
    write_ok("interp_status_clear", REG_STATUS, 32'h1);
    model_sat = 1'b0;
  endtask

  task automatic test_saturation();
    sample_t   seq [4] = '{16'sh8000, 16'sh7fff, 16'sh7fff, 16'sh8000};
    dac_word_u w;
    dac_word_u e0;
    dac_word_u e1;
    dac_word_u clip;
    set_mode(1'b0);
    set_mode(1'b1);
    read_expect("sat_status_before", REG_STATUS, 32'h0);
    for (int i = 0; i < 4; i++) begin
      w.ch.ch1 = '0;
      w.ch.ch0 = seq[i];
      model_push(w, e0, e1);
      send_word(w);
      take_sample("sat_phase0", e0);
      if (i == 3) begin
        // Centre sum is 655342, so the shifted value is far above full scale
        clip.raw = 32'h0000_7fff;
        take_sample("sat_clip", clip);
      end else begin
        take_sample("sat_phase1", e1);
      end
    end
    read_expect("sat_status_set", REG_STATUS, 32'h1);
    write_ok("sat_status_clear", REG_STATUS, 32'h1);
    read_expect("sat_status_after", REG_STATUS, 32'h0);
    model_sat = 1'b0;
  endtask

  task automatic test_backpressure();
    dac_word_u w [3];
    dac_word_u e0 [3];
    dac_word_u e1 [3];
    set_mode(1'b0);
    set_mode(1'b1);
    for (int i = 0; i < 3; i++) begin
      w[i].raw = $random(seed);
      model_push(w[i], e0[i], e1[i]);
    end
    send_word(w[0]);
    // The second word waits for the whole first pair to drain
    fork
      send_word(w[1]);
      begin
        hold_off(5, "bp_first");
        take_sample("bp_w0_phase0", e0[0]);
        hold_off(3, "bp_second");
        take_sample("bp_w0_phase1", e1[0]);
      end
    join
    take_sample("bp_w1_phase0", e0[1]);
    hold_off(2, "bp_third");
    take_sample("bp_w1_phase1", e1[1]);
    send_word(w[2]);
    take_sample("bp_w2_phase0", e0[2]);
    take_sample("bp_w2_phase1", e1[2]);
    expect_idle("backpressure");
    read_expect("bp_count", REG_COUNT, taken);
  endtask

  task automatic test_unmapped();
    logic [31:0] data;
    axi_resp_t   resp;
    write_ok("unmapped_setup", REG_CTRL, 32'h1);
    axi_write(32'hC, 32'h0, resp);
    check_resp("unmapped_write", RESP_SLVERR, resp);
    read_expect("unmapped_ctrl_kept", REG_CTRL, 32'h1);
    axi_read(32'hC, data, resp);
    check_resp("unmapped_read", RESP_SLVERR, resp);
    check_reg("unmapped_rdata", 32'h0, data);
    set_mode(1'b0);
  endtask

  // **********************************************************************
  // Run
  // **********************************************************************
  always @(negedge aclk) begin
    if (dut_i.asserts_i.failed) begin
      fail_now("a protocol assertion on the DUT ports failed");
    end
  end

  initial begin
    seed               = 32'hcedd_1a85;
    taken              = 0;
    model_sat          = 1'b0;
    rst_n              = 1'b0;
    s_axis_data_tvalid = 1'b0;
    s_axis_data_tdata  = 32'h0;
    dac_read           = 1'b0;
    s_axi_awaddr       = '0;
    s_axi_awvalid      = 1'b0;
    s_axi_wdata        = 32'h0;
    s_axi_wvalid       = 1'b0;
    s_axi_bready       = 1'b0;
    s_axi_araddr       = '0;
    s_axi_arvalid      = 1'b0;
    s_axi_rready       = 1'b0;
    model_clear();
    repeat (16) @(posedge aclk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    test_reset_regs();
    test_bypass();
    test_interp();
    test_saturation();
    test_backpressure();
    test_unmapped();
    if (dut_i.asserts_i.failed) begin
      $display("a protocol assertion failed during the run");
      $display("test failed");
      $fatal(1, "simulation stopped");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule
